// ==== common/fpu_pkg.sv ====
////////////////////////////////////////////////////////////
// single precision only; subnormals are taken as zero by the
// arithmetic units, rounding is truncation toward zero
////////////////////////////////////////////////////////////
package fpu_pkg;

  // one float word, seen as raw bits or as ieee fields
  typedef union packed {
    logic [31:0] raw;     // moves, integer view
    struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] man;
    } f;
  } fp_word_t;

  //////////////////////////////////////////////////////////
  // operation select codes
  localparam logic [4:0] op_fadd    = 5'd0;
  localparam logic [4:0] op_fsub    = 5'd1;
  localparam logic [4:0] op_fmul    = 5'd2;
  localparam logic [4:0] op_fsgnj   = 5'd5;
  localparam logic [4:0] op_fsgnjn  = 5'd6;
  localparam logic [4:0] op_fsgnjx  = 5'd7;
  localparam logic [4:0] op_fmax    = 5'd8;
  localparam logic [4:0] op_fmin    = 5'd9;
  localparam logic [4:0] op_feq     = 5'd10;
  localparam logic [4:0] op_flt     = 5'd11;
  localparam logic [4:0] op_fle     = 5'd12;
  localparam logic [4:0] op_fmv_x_w = 5'd13;
  localparam logic [4:0] op_fclass  = 5'd14;
  localparam logic [4:0] op_fmv_w_x = 5'd15;

  // float constants
  localparam logic [31:0] fp_canon_nan = 32'h7fc0_0000;
  localparam logic [31:0] fp_pos_inf   = 32'h7f80_0000;
  localparam logic [7:0]  fp_exp_bias  = 8'd127;
  localparam logic [7:0]  fp_exp_max   = 8'd255;

  //////////////////////////////////////////////////////////
  // fsm encodings
  localparam logic [2:0] add_idle  = 3'd0;
  localparam logic [2:0] add_align = 3'd1;  // one bit per cycle
  localparam logic [2:0] add_sum   = 3'd2;
  localparam logic [2:0] add_norm  = 3'd3;  // one bit per cycle
  localparam logic [2:0] add_pack  = 3'd4;
  localparam logic [1:0] mul_idle  = 2'd0;
  localparam logic [1:0] mul_prod  = 2'd1;
  localparam logic [1:0] mul_norm  = 2'd2;
  localparam logic [1:0] mul_pack  = 2'd3;
  localparam logic       core_idle = 1'b0;
  localparam logic       core_busy = 1'b1;

endpackage

// ==== fpu_core.f ====
+incdir+tb
common/fpu_pkg.sv
verilog/fp_compare.sv
verilog/fp_bitops.sv
fpu_core/fp_add.sv
fpu_core/fp_mul.sv
fpu_core/fpu_core.sv
tb/fpu_core_tb.sv

// ==== fpu_core/fp_add.sv ====
////////////////////////////////////////////////////////////
// no guard bits kept; subnormal in counts as zero
// latency 1 cycle for specials, up to about 54 otherwise
////////////////////////////////////////////////////////////
module fp_add (
  input  logic              g_clk,
  input  logic              g_rst,
  input  logic              start,     // one-cycle launch
  input  logic              sub,       // subtract, negates b
  input  fpu_pkg::fp_word_t a,
  input  fpu_pkg::fp_word_t b,
  output fpu_pkg::fp_word_t result,
  output logic              done       // result valid this cycle
);
  import fpu_pkg::*;

  logic [2:0]        st;
  logic              sa, sb, sr;       // operand and result signs
  logic [7:0]        ea, eb;
  logic [23:0]       ma, mb;           // hidden bit included
  logic [24:0]       sum;              // one carry bit on top
  logic signed [9:0] er;               // room for over/underflow

  logic     bs;                        // effective sign of b
  logic     a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
  logic     spec_hit;
  fp_word_t spec_res;

  assign bs     = b.f.sign ^ sub;
  assign a_zero = (a.f.exp == '0);     // subnormals too
  assign b_zero = (b.f.exp == '0);
  assign a_inf  = (a.f.exp == fp_exp_max) && (a.f.man == '0);
  assign b_inf  = (b.f.exp == fp_exp_max) && (b.f.man == '0);
  assign a_nan  = (a.f.exp == fp_exp_max) && (a.f.man != '0);
  assign b_nan  = (b.f.exp == fp_exp_max) && (b.f.man != '0);

  // special cases settled straight from the inputs
  always_comb begin
    spec_hit     = 1'b1;
    spec_res.raw = fp_canon_nan;
    if (a_nan || b_nan || (a_inf && b_inf && (a.f.sign != bs))) begin
      spec_res.raw = fp_canon_nan;     // nan, or inf - inf
    end else if (a_inf) begin
      spec_res = a;
    end else if (b_inf) begin
      spec_res.raw = {bs, b.raw[30:0]};
    end else if (a_zero && b_zero) begin
      spec_res.raw = {a.f.sign & bs, 31'b0};  // -0 only if both -0
    end else if (a_zero) begin
      spec_res.raw = {bs, b.raw[30:0]};
    end else if (b_zero) begin
      spec_res = a;
    end else begin
      spec_hit = 1'b0;
    end
  end

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      st   <= add_idle;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (st)
        add_idle: if (start) begin
          if (spec_hit) begin
            result <= spec_res;
            done   <= 1'b1;
          end else begin
            sa <= a.f.sign;
            sb <= bs;
            ea <= a.f.exp;
            eb <= b.f.exp;
            ma <= {1'b1, a.f.man};
            mb <= {1'b1, b.f.man};
            st <= add_align;
          end
        end
        add_align: begin               // shift the smaller one right
          if (ea == eb) begin
            st <= add_sum;
          end else if (ea < eb) begin
            if (ma == '0) ea <= eb;    // all bits gone, snap
            else begin
              ma <= ma >> 1;
              ea <= ea + 8'd1;
            end
          end else begin
            if (mb == '0) eb <= ea;
            else begin
              mb <= mb >> 1;
              eb <= eb + 8'd1;
            end
          end
        end
        add_sum: begin
          er <= {2'b00, ea};
          if (sa == sb) begin
            sum <= {1'b0, ma} + {1'b0, mb};
            sr  <= sa;
          end else if (ma >= mb) begin
            sum <= {1'b0, ma - mb};
            sr  <= sa;
          end else begin
            sum <= {1'b0, mb - ma};
            sr  <= sb;
          end
          st <= add_norm;
        end
        add_norm: begin
          if (sum == '0) begin
            st <= add_pack;            // exact cancellation
          end else if (sum[24]) begin
            sum <= sum >> 1;           // carry out, lsb dropped
            er  <= er + 10'sd1;
          end else if (!sum[23]) begin
            sum <= sum << 1;
            er  <= er - 10'sd1;
          end else begin
            st <= add_pack;
          end
        end
        default: begin                 // add_pack
          done <= 1'b1;
          st   <= add_idle;
          if (sum == '0) result.raw <= '0;  // cancelled sum is +0
          else if (er >= $signed({2'b00, fp_exp_max})) result.raw <= {sr, fp_pos_inf[30:0]};
          else if (er <= 10'sd0) result.raw <= {sr, 31'b0};  // flush tiny
          else begin
            result.f.sign <= sr;
            result.f.exp  <= er[7:0];
            result.f.man  <= sum[22:0];
          end
        end
      endcase
    end
  end

endmodule

// ==== fpu_core/fp_mul.sv ====
////////////////////////////////////////////////////////////
// done exactly 4 cycles after start; truncating, no subnormals
////////////////////////////////////////////////////////////
module fp_mul (
  input  logic              g_clk,
  input  logic              g_rst,
  input  logic              start,
  input  fpu_pkg::fp_word_t a,
  input  fpu_pkg::fp_word_t b,
  output fpu_pkg::fp_word_t result,
  output logic              done
);
  import fpu_pkg::*;

  logic [1:0]        st;
  logic              spec;             // special case caught at unpack
  fp_word_t          spec_res;
  logic              sr;
  logic signed [9:0] er;               // biased, may leave 1..254
  logic [23:0]       ma, mb;
  logic [47:0]       prod;
  logic [22:0]       mn;               // normalized fraction

  logic a_nan, b_nan, a_inf, b_inf, a_zero, b_zero, s;

  assign s      = a.f.sign ^ b.f.sign;
  assign a_zero = (a.f.exp == '0);     // subnormal as zero
  assign b_zero = (b.f.exp == '0);
  assign a_inf  = (a.f.exp == fp_exp_max) && (a.f.man == '0);
  assign b_inf  = (b.f.exp == fp_exp_max) && (b.f.man == '0);
  assign a_nan  = (a.f.exp == fp_exp_max) && (a.f.man != '0);
  assign b_nan  = (b.f.exp == fp_exp_max) && (b.f.man != '0);

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      st   <= mul_idle;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (st)
        mul_idle: if (start) begin     // unpack stage
          spec <= a_nan || b_nan || a_inf || b_inf || a_zero || b_zero;
          if (a_nan || b_nan || ((a_inf || b_inf) && (a_zero || b_zero)))
            spec_res.raw <= fp_canon_nan;  // nan, inf * 0
          else if (a_inf || b_inf) spec_res.raw <= {s, fp_pos_inf[30:0]};
          else spec_res.raw <= {s, 31'b0};
          sr <= s;
          er <= $signed({2'b00, a.f.exp}) + $signed({2'b00, b.f.exp})
                - $signed({2'b00, fp_exp_bias});
          ma <= {1'b1, a.f.man};
          mb <= {1'b1, b.f.man};
          st <= mul_prod;
        end
        mul_prod: begin
          prod <= ma * mb;             // 24 x 24
          st   <= mul_norm;
        end
        mul_norm: begin                // product in [1,4), one step
          if (prod[47]) begin
            mn <= prod[46:24];
            er <= er + 10'sd1;
          end else begin
            mn <= prod[45:23];
          end
          st <= mul_pack;
        end
        default: begin                 // mul_pack
          done <= 1'b1;
          st   <= mul_idle;
          if (spec) result <= spec_res;
          else if (er >= $signed({2'b00, fp_exp_max})) result.raw <= {sr, fp_pos_inf[30:0]};
          else if (er <= 10'sd0) result.raw <= {sr, 31'b0};
          else begin
            result.f.sign <= sr;
            result.f.exp  <= er[7:0];
            result.f.man  <= mn;       // truncated
          end
        end
      endcase
    end
  end

endmodule

// ==== fpu_core/fpu_core.sv ====
////////////////////////////////////////////////////////////
// upstream must hold fpu_sel, a and b while stall is high;
// one op in flight, res is valid the cycle after acceptance
////////////////////////////////////////////////////////////
module fpu_core (
  input  logic              g_clk,
  input  logic              g_rst,
  input  logic [4:0]        fpu_sel,   // operation select from decode
  input  fpu_pkg::fp_word_t a,
  input  fpu_pkg::fp_word_t b,
  output fpu_pkg::fp_word_t res,
  output logic              stall      // hold the pipeline
);
  import fpu_pkg::*;

  logic     state;                     // idle / busy
  logic     is_add, is_mul, is_arith;
  logic     add_start, mul_start;
  logic     add_done, mul_done, unit_done;
  logic     capture;
  fp_word_t add_res, mul_res, cmp_res, sgnj_res, misc_res;
  fp_word_t next_res;

  ////////////////////////////////////////////////////////////
  // decode and launch
  assign is_add   = (fpu_sel == op_fadd) || (fpu_sel == op_fsub);
  assign is_mul   = (fpu_sel == op_fmul);
  assign is_arith = is_add || is_mul;

  assign add_start = (state == core_idle) && is_add;  // first cycle only
  assign mul_start = (state == core_idle) && is_mul;
  assign unit_done = is_add ? add_done : mul_done;

  // high from the first cycle, drops in the done cycle
  assign stall   = is_arith && !((state == core_busy) && unit_done);
  assign capture = !stall;

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      state <= core_idle;
    end else if (state == core_idle) begin
      if (is_arith) state <= core_busy;
    end else if (unit_done) begin
      state <= core_idle;               // retire, next op starts fresh
    end
  end

  ////////////////////////////////////////////////////////////
  // execution units
  fp_add u_fp_add (
    .g_clk  (g_clk),
    .g_rst  (g_rst),
    .start  (add_start),
    .sub    (fpu_sel == op_fsub),        // sign of b flipped inside
    .a      (a),
    .b      (b),
    .result (add_res),
    .done   (add_done)
  );

  fp_mul u_fp_mul (
    .g_clk  (g_clk),
    .g_rst  (g_rst),
    .start  (mul_start),
    .a      (a),
    .b      (b),
    .result (mul_res),
    .done   (mul_done)
  );

  fp_compare u_fp_compare (
    .a       (a),
    .b       (b),
    .cmp_sel (fpu_sel[2:0]),
    .result  (cmp_res)
  );

  fp_bitops u_fp_bitops (
    .a           (a),
    .b           (b),
    .bit_sel     (fpu_sel[1:0]),
    .sgnj_result (sgnj_res),
    .misc_result (misc_res)
  );

  // result select
  always_comb begin
    case (fpu_sel)
      op_fadd, op_fsub:                   next_res = add_res;
      op_fmul:                            next_res = mul_res;
      op_fsgnj, op_fsgnjn, op_fsgnjx:     next_res = sgnj_res;
      op_fmax, op_fmin, op_feq, op_flt,
      op_fle:                             next_res = cmp_res;
      op_fmv_x_w, op_fclass, op_fmv_w_x:  next_res = misc_res;
      default:                            next_res.raw = fp_canon_nan;
    endcase
  end

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      res <= '0;
    end else if (capture) begin
      res <= next_res;                  // unit result only valid with done
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the fpu_core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timescale 1ns/1ps --top-module fpu_core_tb \
    -f fpu_core.f -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vfpu_core_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== tb/fpu_ref_model.svh ====
////////////////////////////////////////////////////////////
// expected results from the numeric rules; include inside a
// module that imports fpu_pkg
////////////////////////////////////////////////////////////
`ifndef fpu_ref_model_svh
`define fpu_ref_model_svh

function automatic logic is_nan(input fp_word_t x);
  return (x.f.exp == 8'hff) && (x.f.man != '0);
endfunction

// monotonic key over non-nan words, -0 sorts below +0
function automatic logic [31:0] order_key(input fp_word_t x);
  return x.f.sign ? ~x.raw : {1'b1, x.raw[30:0]};
endfunction

// truncating add, shifted-out bits of the smaller operand are lost
function automatic logic [31:0] sum_of(input fp_word_t x, input fp_word_t y, input logic sub);
  logic        sx, sy, sr;
  int          ex, ey, er;
  logic [24:0] mx, my, m;
  sx = x.f.sign;
  sy = y.f.sign ^ sub;                 // effective sign of y
  ex = int'(x.f.exp);
  ey = int'(y.f.exp);
  if (is_nan(x) || is_nan(y)) return fp_canon_nan;
  if (ex == 255 && ey == 255 && sx != sy) return fp_canon_nan;  // inf - inf
  if (ex == 255) return x.raw;
  if (ey == 255) return {sy, y.raw[30:0]};
  if (ex == 0 && ey == 0) return {sx & sy, 31'b0};  // subnormals are zeros
  if (ex == 0) return {sy, y.raw[30:0]};
  if (ey == 0) return x.raw;
  er = (ex > ey) ? ex : ey;
  mx = {2'b01, x.f.man} >> (er - ex);
  my = {2'b01, y.f.man} >> (er - ey);
  if (sx == sy) begin
    m  = mx + my;
    sr = sx;
  end else if (mx >= my) begin
    m  = mx - my;
    sr = sx;
  end else begin
    m  = my - mx;
    sr = sy;
  end
  if (m == '0) return 32'h0;           // exact zero sum is +0
  if (m[24]) begin
    m  = m >> 1;                       // carry, lsb dropped
    er = er + 1;
  end
  while (!m[23]) begin
    m  = m << 1;
    er = er - 1;
  end
  if (er >= 255) return {sr, fp_pos_inf[30:0]};
  if (er <= 0) return {sr, 31'b0};     // flush tiny
  return {sr, 8'(er), m[22:0]};
endfunction

function automatic logic [31:0] product_of(input fp_word_t x, input fp_word_t y);
  logic        s, x_inf, y_inf, x_zero, y_zero;
  int          e;
  logic [47:0] p;
  s      = x.f.sign ^ y.f.sign;
  x_inf  = (x.f.exp == 8'hff) && (x.f.man == '0);
  y_inf  = (y.f.exp == 8'hff) && (y.f.man == '0);
  x_zero = (x.f.exp == 8'h00);         // subnormal too
  y_zero = (y.f.exp == 8'h00);
  if (is_nan(x) || is_nan(y)) return fp_canon_nan;
  if ((x_inf || y_inf) && (x_zero || y_zero)) return fp_canon_nan;
  if (x_inf || y_inf) return {s, fp_pos_inf[30:0]};
  if (x_zero || y_zero) return {s, 31'b0};
  e = int'(x.f.exp) + int'(y.f.exp) - int'(fp_exp_bias);
  p = {24'b0, 1'b1, x.f.man} * {24'b0, 1'b1, y.f.man};
  if (p[47]) e = e + 1;                // product in [2,4)
  if (e >= 255) return {s, fp_pos_inf[30:0]};
  if (e <= 0) return {s, 31'b0};
  return {s, 8'(e), p[47] ? p[46:24] : p[45:23]};
endfunction

function automatic logic [31:0] compare_answer(input logic [4:0] sel, input fp_word_t x,
                                               input fp_word_t y);
  logic nan_x, nan_y, zeros, less, same;
  nan_x = is_nan(x);
  nan_y = is_nan(y);
  zeros = (x.raw[30:0] == '0) && (y.raw[30:0] == '0);
  less  = order_key(x) < order_key(y);
  same  = (x.raw == y.raw) || zeros;   // +0 equals -0
  case (sel)
    op_feq:  return {31'b0, !nan_x && !nan_y && same};
    op_flt:  return {31'b0, !nan_x && !nan_y && less && !zeros};
    op_fle:  return {31'b0, !nan_x && !nan_y && (less || same)};
    default: ;
  endcase
  if (nan_x && nan_y) return fp_canon_nan;
  if (nan_x) return y.raw;             // the other operand wins
  if (nan_y) return x.raw;
  if (sel == op_fmin) return less ? x.raw : y.raw;
  return less ? y.raw : x.raw;
endfunction

// riscv fclass, bit 0 is -inf up to bit 9 quiet nan
function automatic logic [31:0] class_bits(input fp_word_t x);
  int k;
  if (x.f.exp == 8'hff) begin
    if (x.f.man == '0) k = x.f.sign ? 0 : 7;
    else k = x.f.man[22] ? 9 : 8;
  end else if (x.f.exp == 8'h00) begin
    if (x.f.man == '0) k = x.f.sign ? 3 : 4;
    else k = x.f.sign ? 2 : 5;
  end else begin
    k = x.f.sign ? 1 : 6;
  end
  return 32'd1 << k;
endfunction

function automatic logic [31:0] expected_result(input logic [4:0] sel, input fp_word_t x,
                                                input fp_word_t y);
  case (sel)
    op_fadd:                                 return sum_of(x, y, 1'b0);
    op_fsub:                                 return sum_of(x, y, 1'b1);
    op_fmul:                                 return product_of(x, y);
    op_fsgnj:                                return {y.f.sign, x.raw[30:0]};
    op_fsgnjn:                               return {~y.f.sign, x.raw[30:0]};
    op_fsgnjx:                               return {x.f.sign ^ y.f.sign, x.raw[30:0]};
    op_fmax, op_fmin, op_feq, op_flt, op_fle: return compare_answer(sel, x, y);
    op_fmv_x_w, op_fmv_w_x:                  return x.raw;
    op_fclass:                               return class_bits(x);
    default:                                 return fp_canon_nan;
  endcase
endfunction

`endif

// ==== tb/fpu_core_tb.sv ====
////////////////////////////////////////////////////////////
// one op in flight and held while stall is high; needs tb/
// on the include path for the reference model
////////////////////////////////////////////////////////////
module fpu_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fpu_pkg::*;

  localparam int n_rand     = 24;     // random ops per group
  localparam int n_special  = 16;
  localparam int num_ops    = 20 + 17 * n_rand + n_special + 8 * n_special * n_special;
  localparam int timeout_ns = (num_ops + 1) * 60 * 4;

  logic       g_clk;
  logic       g_rst;
  logic [4:0] fpu_sel;
  fp_word_t   a, b;
  fp_word_t   res;
  logic       stall;

  logic [31:0] want_q[$];             // expected res in issue order
  logic [4:0]  sel_q[$];
  int          ops_done = 0;

  // every fclass class plus the edges of the normal range
  logic [31:0] special_vals [0:n_special-1] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,  // zeros, infs
    32'h7fc0_0000, 32'h7f80_0001, 32'hffc0_0000, 32'h0000_0001,  // nans, +sub
    32'h807f_ffff, 32'h3f80_0000, 32'hbf80_0000, 32'h7f7f_ffff,
    32'hff7f_ffff, 32'h0080_0000, 32'h8080_0000, 32'h4000_0000
  };

  `include "fpu_ref_model.svh"

  fpu_core u_fpu_core (
    .g_clk   (g_clk),
    .g_rst   (g_rst),
    .fpu_sel (fpu_sel),
    .a       (a),
    .b       (b),
    .res     (res),
    .stall   (stall)
  );

  initial g_clk = 1'b0;
  always #2 g_clk = ~g_clk;           // 4 ns period

  ////////////////////////////////////////////////////////////
  // failure and compare helpers
  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      stop_on_failure($sformatf("error: %s got %h expected %h", name, got, want));
    end
  endtask

  function automatic logic [31:0] random_normal(input int exp_lo, input int exp_hi);
    logic [7:0] e;
    e = 8'($urandom_range(exp_hi, exp_lo));
    return {1'($urandom_range(1, 0)), e, 23'($urandom())};
  endfunction

  // called at posedge + 0.5, returns at posedge + 0.5 after acceptance
  task automatic issue_op(input logic [4:0] sel, input logic [31:0] x, input logic [31:0] y);
    int held;
    fpu_sel = sel;
    a.raw   = x;
    b.raw   = y;
    held    = 0;
    @(negedge g_clk);
    while (stall) begin               // inputs stay put
      held++;
      @(negedge g_clk);
    end
    if (sel == op_fmul) begin
      check_equal($sformatf("stall cycles (op %0d)", sel), held, 4);
    end else if (sel == op_fadd || sel == op_fsub) begin
      if (held < 1 || held > 56) begin
        stop_on_failure($sformatf("add held stall for %0d cycles, expected 1 to 56", held));
      end
    end else begin
      check_equal($sformatf("stall cycles (op %0d)", sel), held, 0);
    end
    want_q.push_back(expected_result(sel, x, y));  // captured at next edge
    sel_q.push_back(sel);
    ops_done++;
    @(posedge g_clk);
    #0.5;
  endtask

  ////////////////////////////////////////////////////////////
  // result checker pops one entry per accepted op
  initial begin : compare_results
    logic [31:0] want;
    logic [4:0]  sel;
    forever begin
      @(posedge g_clk);
      #1;                             // res settled after the edge
      if (want_q.size() != 0) begin
        want = want_q.pop_front();
        sel  = sel_q.pop_front();
        check_equal($sformatf("res (op %0d)", sel), res.raw, want);
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    stop_on_failure($sformatf("timeout after %0d ns with %0d of %0d ops done",
                              timeout_ns, ops_done, num_ops));
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  initial begin
    logic [31:0] x, y;
    void'($urandom(79443));
    g_rst   = 1'b1;
    fpu_sel = op_fmv_x_w;             // move of zero as idle bubble
    a       = '0;
    b       = '0;
    repeat (10) @(posedge g_clk);
    #0.5;
    g_rst = 1'b0;
    @(negedge g_clk);
    check_equal("stall", {31'b0, stall}, 32'h0);
    check_equal("res", res.raw, 32'h0);
    @(posedge g_clk);
    #0.5;

    // unused codes give canonical nan
    issue_op(5'd3, $urandom(), $urandom());
    issue_op(5'd4, $urandom(), $urandom());
    for (int c = 16; c < 32; c++) issue_op(5'(c), $urandom(), $urandom());

    // add and sub with close exponents so alignment and cancellation run
    for (int i = 0; i < n_rand; i++) begin
      x = random_normal(110, 140);
      y = random_normal(110, 140);
      issue_op(op_fadd, x, y);
      issue_op(op_fsub, x, y);
      issue_op(op_fsub, x, x);        // exact zero
      issue_op(op_fadd, x, {~x[31], x[30:23], 23'($urandom())});  // deep cancel
    end

    for (int i = 0; i < n_rand; i++) begin
      issue_op(op_fmul, random_normal(100, 154), random_normal(100, 154));
      issue_op(op_fmul, random_normal(1, 254), random_normal(1, 254));  // over/underflow
    end
    issue_op(op_fmul, 32'h7f00_0000, 32'h7f00_0000);
    issue_op(op_fmul, 32'h0080_0000, 32'h0080_0000);

    // every special pair through arithmetic and compare
    for (int i = 0; i < n_special; i++) begin
      for (int j = 0; j < n_special; j++) begin
        issue_op(op_fadd, special_vals[i], special_vals[j]);
        issue_op(op_fsub, special_vals[i], special_vals[j]);
        issue_op(op_fmul, special_vals[i], special_vals[j]);
        issue_op(op_fmax, special_vals[i], special_vals[j]);
        issue_op(op_fmin, special_vals[i], special_vals[j]);
        issue_op(op_feq, special_vals[i], special_vals[j]);
        issue_op(op_flt, special_vals[i], special_vals[j]);
        issue_op(op_fle, special_vals[i], special_vals[j]);
      end
    end

    for (int i = 0; i < n_rand; i++) begin
      x = $urandom();
      y = $urandom();
      issue_op(op_fsgnj, x, y);
      issue_op(op_fsgnjn, x, y);
      issue_op(op_fsgnjx, x, y);
      issue_op(op_fmv_x_w, x, y);
      issue_op(op_fmv_w_x, x, y);
      issue_op(op_fclass, x, y);
    end
    for (int i = 0; i < n_special; i++) issue_op(op_fclass, special_vals[i], $urandom());

    for (int i = 0; i < n_rand; i++) begin
      x = $urandom();
      y = ($urandom_range(3, 0) == 0) ? x : $urandom();  // some equal pairs
      issue_op(op_fmax, x, y);
      issue_op(op_fmin, x, y);
      issue_op(op_feq, x, y);
      issue_op(op_flt, x, y);
      issue_op(op_fle, x, y);
    end

    @(negedge g_clk);                 // last result checked by now
    check_equal("ops issued", ops_done, num_ops);
    if (want_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_on_failure("results left unchecked at the end of the run");
    end
  end

endmodule

// ==== verilog/fp_bitops.sv ====
////////////////////////////////////////////////////////////
// combinational; fclass reads raw bits, subnormals reported
////////////////////////////////////////////////////////////
module fp_bitops (
  input  fpu_pkg::fp_word_t a,
  input  fpu_pkg::fp_word_t b,
  input  logic [1:0]        bit_sel,      // low op code bits
  output fpu_pkg::fp_word_t sgnj_result,  // fsgnj family
  output fpu_pkg::fp_word_t misc_result   // moves or fclass
);
  import fpu_pkg::*;

  logic       exp_ones, exp_zero, man_zero;
  logic [9:0] cls;                     // one-hot class

  // sign injection, magnitude always from a
  always_comb begin
    sgnj_result = a;
    case (bit_sel)
      2'b01:   sgnj_result.f.sign = b.f.sign;             // fsgnj
      2'b10:   sgnj_result.f.sign = ~b.f.sign;            // fsgnjn
      2'b11:   sgnj_result.f.sign = a.f.sign ^ b.f.sign;  // fsgnjx
      default: sgnj_result.f.sign = a.f.sign;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // classification of a
  assign exp_ones = (a.f.exp == fp_exp_max);
  assign exp_zero = (a.f.exp == '0);
  assign man_zero = (a.f.man == '0);

  assign cls[0] =  a.f.sign && exp_ones && man_zero;   // -inf
  assign cls[1] =  a.f.sign && !exp_ones && !exp_zero; // -normal
  assign cls[2] =  a.f.sign && exp_zero && !man_zero;  // -subnormal
  assign cls[3] =  a.f.sign && exp_zero && man_zero;   // -0
  assign cls[4] = !a.f.sign && exp_zero && man_zero;   // +0
  assign cls[5] = !a.f.sign && exp_zero && !man_zero;
  assign cls[6] = !a.f.sign && !exp_ones && !exp_zero;
  assign cls[7] = !a.f.sign && exp_ones && man_zero;   // +inf
  assign cls[8] = exp_ones && !man_zero && !a.f.man[22];  // signaling
  assign cls[9] = exp_ones && a.f.man[22];              // quiet nan

  // fclass on 2'b10, both moves pass a bit for bit
  assign misc_result.raw = (bit_sel == 2'b10) ? {22'b0, cls} : a.raw;

endmodule

// ==== verilog/fp_compare.sv ====
////////////////////////////////////////////////////////////
// combinational; cmp_sel is the low 3 bits of the op code
////////////////////////////////////////////////////////////
module fp_compare (
  input  fpu_pkg::fp_word_t a,
  input  fpu_pkg::fp_word_t b,
  input  logic [2:0]        cmp_sel,   // max min eq lt le
  output fpu_pkg::fp_word_t result
);
  import fpu_pkg::*;

  logic a_nan, b_nan, any_nan;
  logic both_zero;
  logic ord_lt;                        // total order, -0 < +0
  logic eq, lt;

  assign a_nan     = (a.f.exp == fp_exp_max) && (a.f.man != '0);
  assign b_nan     = (b.f.exp == fp_exp_max) && (b.f.man != '0);
  assign any_nan   = a_nan || b_nan;
  assign both_zero = (a.raw[30:0] == '0) && (b.raw[30:0] == '0);

  // sign first, then magnitude; reversed when both negative
  always_comb begin
    if (a.f.sign != b.f.sign) ord_lt = a.f.sign;
    else if (a.f.sign)        ord_lt = a.raw[30:0] > b.raw[30:0];
    else                      ord_lt = a.raw[30:0] < b.raw[30:0];
  end

  assign eq = (a.raw == b.raw) || both_zero;  // +0 == -0
  assign lt = ord_lt && !both_zero;

  always_comb begin
    result.raw = '0;
    case (cmp_sel)
      3'b000, 3'b001: begin            // fmax, fmin
        if (a_nan && b_nan)            result.raw = fp_canon_nan;
        else if (a_nan)                result = b;  // the other one wins
        else if (b_nan)                result = a;
        else if (ord_lt ^ cmp_sel[0])  result = b;
        else                           result = a;
      end
      3'b010:  result.raw[0] = !any_nan && eq;
      3'b011:  result.raw[0] = !any_nan && lt;
      3'b100:  result.raw[0] = !any_nan && (lt || eq);
      default: result.raw    = fp_canon_nan;  // not reached from core
    endcase
  end

endmodule
